// ==== design/cpuPkg.sv ====
package cpuPkg;

	localparam int DataWidth = 16; // words, registers, addresses
	localparam int RegAddrWidth = 3; // eight registers

	typedef logic [DataWidth-1:0] word_t;
	typedef logic [RegAddrWidth-1:0] regAddr_t;

	// course encoding, instr[15:11]
	typedef enum logic [4:0] {
		opHalt = 5'b00000, opNop = 5'b00001,
		opJ = 5'b00100, opJr = 5'b00101, opJal = 5'b00110, opJalr = 5'b00111,
		opAddi = 5'b01000, opSubi = 5'b01001, opXori = 5'b01010, opAndni = 5'b01011,
		opBeqz = 5'b01100, opBnez = 5'b01101, opBltz = 5'b01110, opBgez = 5'b01111,
		opSt = 5'b10000, opLd = 5'b10001, opSlbi = 5'b10010, opStu = 5'b10011,
		opRoli = 5'b10100, opSlli = 5'b10101, opRori = 5'b10110, opSrli = 5'b10111,
		opLbi = 5'b11000, opBtr = 5'b11001, opShiftR = 5'b11010, opAluR = 5'b11011,
		opSeq = 5'b11100, opSlt = 5'b11101, opSle = 5'b11110, opSco = 5'b11111
	} opcode_t;

	// low two bits line up with the opcode / func field
	typedef enum logic [2:0] {
		aluRotl, aluShl, aluRotr, aluShr,
		aluAdd, aluSub, aluXor, aluAndn
	} aluOp_t;

	typedef enum logic [2:0] {
		brEqz, brNez, brLtz, brSlt, brGez, brCarry, brSle
	} brOp_t;

	typedef enum logic [2:0] {
		csStopped, csFetchReq, csDecodeExec, csMemAccess, csWriteBack, csHalted
	} coreState_t;

endpackage

// ==== design/fetchUnit.sv ====
`timescale 1ns/100ps
module fetchUnit (
	input logic clk,
	input logic reset,
	input logic run,
	output logic fetchReq,
	output cpuPkg::word_t fetchAddr,
	input logic fetchRValid,
	input cpuPkg::word_t fetchRData,
	input cpuPkg::word_t nextPc,
	input logic memNeeded,
	input logic memDone,
	input logic isHalt,
	output cpuPkg::word_t instr,
	output cpuPkg::word_t pcPlus2,
	output cpuPkg::coreState_t state
);
	import cpuPkg::*;

	word_t pc; // byte address

	assign fetchReq = (state == csFetchReq); // held until rValid
	assign fetchAddr = {1'b0, pc[DataWidth-1:1]}; // word address

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= csStopped;
			pc <= '0;
		end else if (!run) begin
			state <= csStopped; // run low parks the core
		end else begin
			case (state)
				csStopped: begin
					pc <= '0; // program starts at 0
					state <= csFetchReq;
				end
				csFetchReq: if (fetchRValid) state <= csDecodeExec;
				csDecodeExec: begin
					pc <= nextPc; // pc+2 unless taken
					if (isHalt) state <= csHalted;
					else if (memNeeded) state <= csMemAccess;
					else state <= csWriteBack;
				end
				csMemAccess: if (memDone) state <= csWriteBack;
				csWriteBack: state <= csFetchReq;
				default: state <= csHalted; // halted waits for run low
			endcase
		end
	end

	// instruction register and link value
	always_ff @(posedge clk) begin
		if (state == csFetchReq && fetchRValid) begin
			instr <= fetchRData;
			pcPlus2 <= pc + word_t'(2); // kept for jal/jalr link
		end
	end

endmodule

// ==== design/decodeUnit.sv ====
`timescale 1ns/100ps
module decodeUnit (
	input logic clk,
	input logic reset,
	input cpuPkg::word_t instr,
	input cpuPkg::coreState_t state,
	output cpuPkg::word_t reg1,
	output cpuPkg::word_t reg2,
	output logic [7:0] imm8,
	output cpuPkg::word_t jumpOffset,
	output cpuPkg::aluOp_t aluOp,
	output cpuPkg::brOp_t brOp,
	output logic extMode,
	output logic iType,
	output logic reg1Rev,
	output logic reg1Shift,
	output logic zero1,
	output logic zero2,
	output logic aluSrc,
	output logic branch,
	output logic jump,
	output logic setSel,
	output logic linkSel,
	output logic memNeeded,
	output logic memWrite,
	output logic isHalt,
	input cpuPkg::word_t dataOut,
	input cpuPkg::word_t loadData,
	input cpuPkg::word_t pcPlus2,
	output logic wbValid,
	output cpuPkg::regAddr_t wbReg,
	output cpuPkg::word_t wbData
);
	import cpuPkg::*;

	word_t regFile [8];
	opcode_t opcode;
	logic [1:0] destSel; // 0 none, 1 Rd I-format, 2 Rd R-format, 3 Rs
	logic wbPending;

	assign opcode = opcode_t'(instr[15:11]);
	assign reg1 = regFile[instr[10:8]]; // Rs
	assign reg2 = regFile[instr[7:5]]; // Rt, or Rd for st
	assign imm8 = instr[7:0];
	assign jumpOffset = {{5{instr[10]}}, instr[10:0]}; // 11-bit displacement

	always_comb begin
		aluOp = aluAdd;
		brOp = brEqz;
		{extMode, iType, reg1Rev, reg1Shift, zero1, zero2, aluSrc} = '0;
		{branch, jump, setSel, linkSel, memNeeded, memWrite, isHalt} = '0;
		destSel = 2'd0;
		case (opcode)
			opHalt: isHalt = 1'b1;
			opAddi, opSubi, opXori, opAndni: begin
				aluOp = aluOp_t'({1'b1, instr[12:11]});
				extMode = ~instr[12]; // add/sub sign extend, logic zero extend
				aluSrc = 1'b1;
				destSel = 2'd1;
			end
			opRoli, opSlli, opRori, opSrli: begin
				aluOp = aluOp_t'({1'b0, instr[12:11]});
				aluSrc = 1'b1;
				destSel = 2'd1;
			end
			opSt, opLd, opStu: begin
				extMode = 1'b1;
				aluSrc = 1'b1;
				memNeeded = 1'b1;
				memWrite = (opcode != opLd);
				if (opcode == opLd) destSel = 2'd1;
				else if (opcode == opStu) destSel = 2'd3; // base update
			end
			opBtr: begin
				reg1Rev = 1'b1;
				zero2 = 1'b1; // reversed Rs + 0
				destSel = 2'd2;
			end
			opAluR, opShiftR: begin
				aluOp = aluOp_t'({instr[11], instr[1:0]}); // func picks the op
				destSel = 2'd2;
			end
			opSeq, opSlt, opSle, opSco: begin
				aluOp = (opcode == opSco) ? aluAdd : aluSub; // Rt - Rs for compares
				case (opcode)
					opSeq: brOp = brEqz;
					opSlt: brOp = brSlt;
					opSle: brOp = brSle;
					default: brOp = brCarry;
				endcase
				setSel = 1'b1;
				destSel = 2'd2;
			end
			opBeqz, opBnez, opBltz, opBgez: begin
				brOp = (opcode == opBeqz) ? brEqz : (opcode == opBnez) ? brNez :
					(opcode == opBltz) ? brLtz : brGez;
				zero2 = 1'b1; // flags of Rs alone
				extMode = 1'b1;
				iType = 1'b1;
				branch = 1'b1;
			end
			opLbi, opSlbi: begin
				zero1 = (opcode == opLbi);
				reg1Shift = (opcode == opSlbi); // (Rs << 8) + zext imm
				extMode = (opcode == opLbi);
				iType = 1'b1;
				aluSrc = 1'b1;
				destSel = 2'd3;
			end
			opJ, opJal, opJr, opJalr: begin
				jump = 1'b1;
				aluSrc = instr[11]; // register forms go through ALU
				iType = 1'b1;
				extMode = 1'b1;
				linkSel = instr[12];
			end
			default: ; // nop
		endcase
	end

	assign wbPending = (destSel != 2'd0) || linkSel;
	assign wbValid = (state == csWriteBack) && wbPending;

	always_comb begin
		if (linkSel) wbReg = regAddr_t'(7); // link register
		else if (destSel == 2'd2) wbReg = instr[4:2];
		else if (destSel == 2'd3) wbReg = instr[10:8];
		else wbReg = instr[7:5];
	end

	assign wbData = (memNeeded && !memWrite) ? loadData : linkSel ? pcPlus2 : dataOut;

	// register file, written only in writeBack
	always_ff @(posedge clk) begin
		if (!reset && wbValid) regFile[wbReg] <= wbData;
	end

endmodule

// ==== design/executeUnit.sv ====
`timescale 1ns/100ps
module executeUnit (
	input cpuPkg::word_t reg1,
	input cpuPkg::word_t reg2,
	input cpuPkg::word_t jumpOffset,
	input cpuPkg::word_t pcPlus2,
	input logic [7:0] imm8,
	input cpuPkg::aluOp_t aluOp,
	input cpuPkg::brOp_t brOp,
	input logic extMode,
	input logic iType,
	input logic reg1Rev,
	input logic reg1Shift,
	input logic zero1,
	input logic zero2,
	input logic aluSrc,
	input logic branch,
	input logic jump,
	input logic setSel,
	output cpuPkg::word_t aluOut,
	output cpuPkg::word_t dataOut,
	output cpuPkg::word_t storeData,
	output cpuPkg::word_t nextPc,
	output logic taken
);
	import cpuPkg::*;

	word_t imm, reg1R, reg1S, aluInA, aluInB, invInA;
	logic [DataWidth:0] sum; // carry in msb
	logic [3:0] shAmt;
	logic [2*DataWidth-1:0] rotL, rotR;
	logic zero, sign, ovf, carry, cond;

	assign storeData = reg2; // Rd of st/stu

	// 5- or 8-bit immediate, sign or zero extended
	always_comb begin
		if (iType) imm = extMode ? {{8{imm8[7]}}, imm8} : {8'h00, imm8};
		else imm = extMode ? {{11{imm8[4]}}, imm8[4:0]} : {11'h000, imm8[4:0]};
	end

	// operand preparation
	always_comb begin
		for (int i = 0; i < DataWidth; i++) reg1R[i] = reg1Rev ? reg1[DataWidth-1-i] : reg1[i];
	end
	assign reg1S = reg1Shift ? {reg1R[7:0], 8'h00} : reg1R; // slbi
	assign aluInA = zero1 ? '0 : reg1S;
	assign aluInB = zero2 ? '0 : (aluSrc ? imm : reg2);

	// adder, sub is B - A
	assign invInA = (aluOp == aluSub) ? ~aluInA : aluInA;
	assign sum = {1'b0, aluInB} + {1'b0, invInA} + (DataWidth+1)'(aluOp == aluSub);
	assign shAmt = aluInB[3:0];
	assign rotL = {aluInA, aluInA} << shAmt; // upper half holds rotl
	assign rotR = {aluInA, aluInA} >> shAmt; // lower half holds rotr

	always_comb begin
		case (aluOp)
			aluRotl: aluOut = rotL[2*DataWidth-1:DataWidth];
			aluShl: aluOut = aluInA << shAmt;
			aluRotr: aluOut = rotR[DataWidth-1:0];
			aluShr: aluOut = aluInA >> shAmt;
			aluXor: aluOut = aluInA ^ aluInB;
			aluAndn: aluOut = aluInA & ~aluInB;
			default: aluOut = sum[DataWidth-1:0]; // add, sub
		endcase
	end

	// flags
	assign zero = (aluOut == '0);
	assign sign = aluOut[DataWidth-1];
	assign carry = sum[DataWidth]; // sco
	assign ovf = (invInA[DataWidth-1] == aluInB[DataWidth-1]) &&
		(sum[DataWidth-1] != aluInB[DataWidth-1]); // signed overflow

	// condition decode, compares look at Rt - Rs
	always_comb begin
		case (brOp)
			brEqz: cond = zero;
			brNez: cond = ~zero;
			brLtz: cond = sign;
			brGez: cond = ~sign;
			brSlt: cond = ~zero & ~(sign ^ ovf); // Rt - Rs > 0
			brSle: cond = ~(sign ^ ovf); // Rt - Rs >= 0
			brCarry: cond = carry;
			default: cond = 1'b0;
		endcase
	end

	assign dataOut = setSel ? {{(DataWidth-1){1'b0}}, cond} : aluOut;

	// next pc, jr/jalr target is Rs + imm from the ALU
	assign taken = (branch & cond) | jump;
	always_comb begin
		if (jump) nextPc = aluSrc ? aluOut : pcPlus2 + jumpOffset;
		else if (branch && cond) nextPc = pcPlus2 + imm;
		else nextPc = pcPlus2;
	end

endmodule

// ==== design/memStage.sv ====
`timescale 1ns/100ps
module memStage (
	input logic clk,
	input logic reset,
	input cpuPkg::coreState_t state,
	input logic memWrite,
	input cpuPkg::word_t addr,
	input cpuPkg::word_t storeData,
	output logic memReq,
	output logic memWe,
	output cpuPkg::word_t memAddr,
	output cpuPkg::word_t memWData,
	input logic memAck,
	input logic memRValid,
	input cpuPkg::word_t memRData,
	output logic memDone,
	output cpuPkg::word_t loadData
);
	import cpuPkg::*;

	assign memReq = (state == csMemAccess); // drops once state moves on
	assign memWe = memWrite;
	assign memAddr = {1'b0, addr[DataWidth-1:1]}; // byte to word address
	assign memWData = storeData;
	assign memDone = memReq && (memAck || memRValid); // end of access

	// hold load result for writeBack
	always_ff @(posedge clk) begin
		if (reset) loadData <= '0;
		else if (memReq && memRValid) loadData <= memRData;
	end

endmodule

// ==== design/memArbiter.sv ====
`timescale 1ns/100ps
module memArbiter #(
	parameter int MemAddrWidth = 10
) (
	input logic clk,
	input logic reset,
	input logic hostReq, hostWe,
	input cpuPkg::word_t hostAddr, hostWData,
	output logic hostAck, hostRValid,
	output cpuPkg::word_t hostRData,
	input logic dataReq, dataWe,
	input cpuPkg::word_t dataAddr, dataWData,
	output logic dataAck, dataRValid,
	output cpuPkg::word_t dataRData,
	input logic fetchReq, fetchWe,
	input cpuPkg::word_t fetchAddr, fetchWData,
	output logic fetchAck, fetchRValid,
	output cpuPkg::word_t fetchRData,
	output logic memEn,
	output logic memWrite,
	output logic [MemAddrWidth-1:0] memAddr,
	output cpuPkg::word_t memWData,
	input cpuPkg::word_t memRData
);
	import cpuPkg::*;

	logic hostOk, dataOk, fetchOk, gHost, gData, gFetch;
	logic pendHost, pendData, pendFetch; // read granted last cycle

	// a reader whose data is due this cycle cannot be granted again
	assign hostOk = hostReq & ~pendHost;
	assign dataOk = dataReq & ~pendData;
	assign fetchOk = fetchReq & ~pendFetch;
	assign gHost = hostOk; // host > mem stage > fetch
	assign gData = dataOk & ~hostOk;
	assign gFetch = fetchOk & ~hostOk & ~dataOk;

	assign memEn = gHost | gData | gFetch;
	always_comb begin
		if (gHost) {memWrite, memAddr, memWData} = {hostWe, hostAddr[MemAddrWidth-1:0], hostWData};
		else if (gData) {memWrite, memAddr, memWData} = {dataWe, dataAddr[MemAddrWidth-1:0], dataWData};
		else {memWrite, memAddr, memWData} = {gFetch & fetchWe, fetchAddr[MemAddrWidth-1:0], fetchWData};
	end

	assign hostAck = gHost & hostWe; // writes end in grant cycle
	assign dataAck = gData & dataWe;
	assign fetchAck = gFetch & fetchWe;

	always_ff @(posedge clk) begin
		if (reset) {pendHost, pendData, pendFetch} <= '0;
		else {pendHost, pendData, pendFetch} <= {gHost & ~hostWe, gData & ~dataWe, gFetch & ~fetchWe};
	end

	// read data steered to the recorded reader only
	assign {hostRValid, dataRValid, fetchRValid} = {pendHost, pendData, pendFetch};
	assign hostRData = pendHost ? memRData : '0;
	assign dataRData = pendData ? memRData : '0;
	assign fetchRData = pendFetch ? memRData : '0;

endmodule

// ==== design/unifiedMemory.sv ====
`timescale 1ns/100ps
module unifiedMemory #(
	parameter int MemAddrWidth = 10
) (
	input logic clk,
	input logic memEn,
	input logic memWrite,
	input logic [MemAddrWidth-1:0] memAddr,
	input cpuPkg::word_t memWData,
	output cpuPkg::word_t memRData
);
	import cpuPkg::*;

	word_t mem [2**MemAddrWidth]; // single port, word addressed

	always_ff @(posedge clk) begin
		if (memEn) begin
			if (memWrite) mem[memAddr] <= memWData;
			else memRData <= mem[memAddr]; // one cycle read latency
		end
	end

endmodule

// ==== design/cpuTop.sv ====
`timescale 1ns/100ps
module cpuTop #(
	parameter int MemAddrWidth = 10
) (
	input logic clk,
	input logic reset,
	input logic run,
	input logic hostRead,
	input logic hostWrite,
	input cpuPkg::word_t hostAddr,
	input cpuPkg::word_t hostWData,
	output logic hostBusy,
	output logic hostRValid,
	output cpuPkg::word_t hostRData,
	output logic wbValid,
	output cpuPkg::regAddr_t wbReg,
	output cpuPkg::word_t wbData,
	output logic halted
);
	import cpuPkg::*;

	coreState_t state;
	word_t instr, pcPlus2, nextPc, fetchAddr, fetchRData, reg1, reg2, jumpOffset;
	word_t aluOut, dataOut, storeData, loadData, dataAddr, dataWData, dataRData, memWData, memRData;
	logic [7:0] imm8;
	logic [MemAddrWidth-1:0] memAddr;
	aluOp_t aluOp;
	brOp_t brOp;
	logic fetchReq, fetchRValid, memNeeded, memDone, isHalt, memWriteCtl;
	logic extMode, iType, reg1Rev, reg1Shift, zero1, zero2, aluSrc;
	logic branch, jump, setSel, linkSel;
	logic dataReq, dataWe, dataAck, dataRValid, hostAck, memEn, memWrite;

	assign hostBusy = (hostRead | hostWrite) & ~hostAck & ~hostRValid;
	assign halted = (state == csHalted);

	fetchUnit fetch (.clk, .reset, .run, .fetchReq, .fetchAddr, .fetchRValid, .fetchRData,
		.nextPc, .memNeeded, .memDone, .isHalt, .instr, .pcPlus2, .state);

	decodeUnit decode (.clk, .reset, .instr, .state, .reg1, .reg2, .imm8, .jumpOffset, .aluOp,
		.brOp, .extMode, .iType, .reg1Rev, .reg1Shift, .zero1, .zero2, .aluSrc, .branch, .jump,
		.setSel, .linkSel, .memNeeded, .memWrite(memWriteCtl), .isHalt, .dataOut, .loadData,
		.pcPlus2, .wbValid, .wbReg, .wbData);

	executeUnit execute (.reg1, .reg2, .jumpOffset, .pcPlus2, .imm8, .aluOp, .brOp, .extMode,
		.iType, .reg1Rev, .reg1Shift, .zero1, .zero2, .aluSrc, .branch, .jump, .setSel, .aluOut,
		.dataOut, .storeData, .nextPc, .taken());

	memStage memory (.clk, .reset, .state, .memWrite(memWriteCtl), .addr(aluOut), .storeData,
		.memReq(dataReq), .memWe(dataWe), .memAddr(dataAddr), .memWData(dataWData),
		.memAck(dataAck), .memRValid(dataRValid), .memRData(dataRData), .memDone, .loadData);

	memArbiter #(.MemAddrWidth(MemAddrWidth)) arbiter (.clk, .reset,
		.hostReq(hostRead | hostWrite), .hostWe(hostWrite), .hostAddr, .hostWData, .hostAck,
		.hostRValid, .hostRData, .dataReq, .dataWe, .dataAddr, .dataWData, .dataAck, .dataRValid,
		.dataRData, .fetchReq, .fetchWe(1'b0), .fetchAddr, .fetchWData('0), .fetchAck(),
		.fetchRValid, .fetchRData, .memEn, .memWrite, .memAddr, .memWData, .memRData);

	unifiedMemory #(.MemAddrWidth(MemAddrWidth)) ram (.clk, .memEn, .memWrite, .memAddr,
		.memWData, .memRData);

endmodule

// ==== bench/benchTable.svh ====
// program image, each entry {byte address, instruction word}
localparam int NumProg = 55;
localparam logic [31:0] progTable [NumProg] = '{
	32'h0000_C180, 32'h0002_9112, 32'h0004_C205, 32'h0006_D94C, // r1 = 8012, r2 = 5, add
	32'h0008_DA31, 32'h000A_D956, 32'h000C_DB5B, 32'h000E_42FD, // sub xor andn addi
	32'h0010_4AE3, 32'h0012_51BF, 32'h0014_59B0, 32'h0016_A1C4, // subi xori andni roli
	32'h0018_A9C3, 32'h001A_B1C5, 32'h001C_B9CF, 32'h001E_CA18, // slli rori srli btr
	32'h0020_D35B, 32'h0022_C380, 32'h0024_9300, 32'h0026_C401, // shr, r3 = 8000, r4 = 1
	32'h0028_EB94, 32'h002A_EC74, 32'h002C_F374, 32'h002E_F474, // slt slt sle sle
	32'h0030_E494, 32'h0032_FB74, 32'h0034_FB94, 32'h0036_6502, // seq sco sco, beqz taken
	32'h0038_C611, 32'h003A_6D02, 32'h003C_C622, 32'h003E_7302, // bnez falls, bltz taken
	32'h0040_C633, 32'h0042_7B02, 32'h0044_C644, 32'h0046_7C02, // bgez falls, bgez taken
	32'h0048_C655, 32'h004A_3002, 32'h004C_C666, 32'h004E_2002, // jal to 4e, j to 52
	32'h0050_C677, 32'h0052_C254, 32'h0054_3A04, 32'h0056_C688, // r2 = 54, jalr to 58
	32'h0058_2A08, 32'h005A_C699, 32'h005C_C401, 32'h005E_9400, // jr to 5c, r4 = 0100
	32'h0060_8420, 32'h0062_8442, 32'h0064_8CA2, 32'h0066_9C7E, // st st ld stu
	32'h0068_8CC0, 32'h006A_0000, 32'h006C_C6CC // ld, halt, never reached
};

// writeback trace in program order, {register, value}
// lbi r6 words at 38 40 48 4c 50 56 5a are skipped and must not show up
localparam int NumWb = 37;
localparam logic [19:0] wbTable [NumWb] = '{
	20'h1_FF80, 20'h1_8012, 20'h2_0005, 20'h3_8017, 20'h4_800D, 20'h5_8017,
	20'h6_8012, 20'h7_0002, 20'h7_FFFE, 20'h5_800D, 20'h5_8002, 20'h6_0128,
	20'h6_0090, 20'h6_9400, 20'h6_0001, 20'h6_A000, 20'h6_0400, 20'h3_FF80,
	20'h3_8000, 20'h4_0001, 20'h5_0001, 20'h5_0000, 20'h5_0001, 20'h5_0000,
	20'h5_0001, 20'h5_0001, 20'h5_0000, 20'h6_0022, 20'h6_0044, 20'h7_004C, // links follow
	20'h2_0054, 20'h7_0056, 20'h4_0001, 20'h4_0100, 20'h5_0054, 20'h4_00FE,
	20'h6_8000
};

// memory after halt, {word address, value}
localparam int NumMem = 3;
localparam logic [31:0] memTable [NumMem] = '{
	32'h007F_8000, // stu at 0100 - 2
	32'h0080_8012,
	32'h0081_0054
};

// ==== bench/cpuBench.sv ====
`timescale 1ns/100ps
module cpuBench;
	import cpuPkg::*;

	localparam int MemAddrWidth = 10;
	localparam int NumData = 8; // lcg words ahead of the program
	localparam int DataBase = 'h100; // word address of lcg block

	`include "benchTable.svh"

	// per instruction budget plus host traffic, in cycles
	localparam int LimitCycles = 40 * NumProg + 4 * (NumProg + 2 * NumData + NumMem) + 20;

	logic clk, reset, run;
	logic hostRead, hostWrite, hostBusy, hostRValid;
	word_t hostAddr, hostWData, hostRData;
	logic wbValid, halted;
	regAddr_t wbReg;
	word_t wbData;

	int errors = 0;
	int checks = 0;
	int wbCount = 0; // records seen so far
	logic [31:0] lcgState = 32'hb0a93cc1;
	word_t dataWords [NumData];

	cpuTop #(.MemAddrWidth(MemAddrWidth)) dut (.clk, .reset, .run, .hostRead, .hostWrite,
		.hostAddr, .hostWData, .hostBusy, .hostRValid, .hostRData, .wbValid, .wbReg, .wbData,
		.halted);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	function automatic logic [31:0] lcgNext(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		checks++;
		if (actual !== expected) begin
			$display("Error at %0t ns: %s got %h expected %h", $time, what, actual, expected);
			errors++;
		end
	endtask

	// one host access, request level held until its end
	task automatic hostAccess(input logic write, input word_t addr, input word_t data,
		output word_t rdata);
		@(posedge clk);
		#1;
		hostRead = !write;
		hostWrite = write;
		hostAddr = addr;
		hostWData = data;
		rdata = 'x;
		do begin
			@(negedge clk); // outputs settled mid cycle
			if (!write && !hostRValid) checkValue(hostBusy, 1, "hostBusy while read waits");
		end while (write ? hostBusy : !hostRValid);
		if (!write) begin
			rdata = hostRData;
			checkValue(hostBusy, 0, "hostBusy in read data cycle"); // request still held
		end
		@(posedge clk);
		#1;
		hostRead = 1'b0;
		hostWrite = 1'b0;
	endtask

	// writeback trace against the table
	always @(negedge clk) begin
		if (wbValid) begin
			if (wbCount >= NumWb) begin
				$display("writeback to r%0d at %0t ns comes after the end of the expected trace",
					wbReg, $time);
				errors++;
			end else begin
				checkValue(wbReg, wbTable[wbCount][19:16], $sformatf("wbReg of record %0d", wbCount));
				checkValue(wbData, wbTable[wbCount][15:0], $sformatf("wbData of record %0d", wbCount));
			end
			wbCount++;
		end
	end

	initial begin
		#(LimitCycles * 4);
		$display("timeout: core never halted");
		$display("Simulation failed");
		$finish;
	end

	initial begin
		word_t got;
		reset = 1'b1;
		run = 1'b0; // core parked while loading
		hostRead = 1'b0;
		hostWrite = 1'b0;
		hostAddr = '0;
		hostWData = '0;
		repeat (8) @(posedge clk);
		#1;
		reset = 1'b0;
		@(negedge clk);
		checkValue(halted, 0, "halted after reset");
		checkValue(wbValid, 0, "wbValid after reset");
		for (int i = 0; i < NumData; i++) begin
			lcgState = lcgNext(lcgState);
			dataWords[i] = lcgState[31:16]; // upper bits, better spread
			hostAccess(1'b1, word_t'(DataBase + i), dataWords[i], got);
		end
		for (int i = 0; i < NumProg; i++) begin
			hostAccess(1'b1, {1'b0, progTable[i][31:17]}, progTable[i][15:0], got); // byte to word
		end
		for (int i = 0; i < NumData; i++) begin
			hostAccess(1'b0, word_t'(DataBase + i), '0, got);
			checkValue(got, dataWords[i], $sformatf("host readback of data word %0d", i));
		end
		@(posedge clk);
		#1;
		run = 1'b1;
		do begin
			@(negedge clk);
		end while (!halted);
		repeat (4) @(negedge clk); // nothing may write after halt
		checkValue(wbCount, NumWb, "writeback count at halt");
		checkValue(halted, 1, "halted level held");
		@(posedge clk);
		#1;
		run = 1'b0;
		for (int i = 0; i < NumMem; i++) begin
			hostAccess(1'b0, memTable[i][31:16], '0, got);
			checkValue(got, memTable[i][15:0], $sformatf("memory word %h", memTable[i][31:16]));
		end
		for (int i = 0; i < NumData; i++) begin
			hostAccess(1'b0, word_t'(DataBase + i), '0, got);
			checkValue(got, dataWords[i], $sformatf("data word %0d after run", i)); // untouched
		end
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== project.f ====
+incdir+bench
design/cpuPkg.sv
design/fetchUnit.sv
design/decodeUnit.sv
design/executeUnit.sv
design/memStage.sv
design/memArbiter.sv
design/unifiedMemory.sv
design/cpuTop.sv
bench/cpuBench.sv

// ==== Bender.yml ====
package:
  name: cpu16

sources:
  - files:
      - design/cpuPkg.sv
      - design/fetchUnit.sv
      - design/decodeUnit.sv
      - design/executeUnit.sv
      - design/memStage.sv
      - design/memArbiter.sv
      - design/unifiedMemory.sv
      - design/cpuTop.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/cpuBench.sv
